// ==== dv/display_checker.sv ====
`timescale 1ns/10ps

module display_checker (
    input  logic                    i_w_clk,
    input  logic                    i_w_reset,
    input  logic                    i_w_next,
    input  logic                    i_w_prev,
    input  display_pkg::reg_addr_t  i_w_regs_addr,
    input  display_pkg::word_t      i_w_regs,
    input  display_pkg::word_t      i_w_ram,
    input  display_pkg::word_t      i_w_bus,
    input  display_pkg::word_t      i_w_state,
    input  logic [7:0]              i_w_an,
    input  display_pkg::seg_t       i_w_7_led_seg,
    output int                      o_errors,
    output int                      o_checks
);

    import display_pkg::*;

    localparam logic [15:0][7:0] HEX_REF = {
        GLYPH_F, GLYPH_E, GLYPH_D, GLYPH_C, GLYPH_B, GLYPH_A, GLYPH_9, GLYPH_8,
        GLYPH_7, GLYPH_6, GLYPH_5, GLYPH_4, GLYPH_3, GLYPH_2, GLYPH_1, GLYPH_0
    };

    logic [1:0] model_view;    // 0 regs, 1 ram, 2 bus, 3 fsm
    logic [2:0] model_digit;
    logic [7:0] exp_an;
    logic [7:0] exp_seg;
    int         errors = 0;
    int         checks = 0;

    // Digit 7 in the top byte
    function automatic logic [31:0] label_ref(input logic [1:0] view, input logic [3:0] addr);
        if (view == 2'd1) return {GLYPH_M_LEFT, GLYPH_M_RIGHT, GLYPH_A, GLYPH_R};
        if (view == 2'd2) return {GLYPH_B, GLYPH_U, GLYPH_S, GLYPH_BLANK};
        if (view == 2'd3) return {GLYPH_F, GLYPH_S, GLYPH_M_LEFT, GLYPH_M_RIGHT};
        case (addr)
            4'd0:    return {GLYPH_R, GLYPH_R, GLYPH_A, GLYPH_BLANK};
            4'd1:    return {GLYPH_R, GLYPH_R, GLYPH_B, GLYPH_BLANK};
            4'd2:    return {GLYPH_R, GLYPH_R, GLYPH_C, GLYPH_BLANK};
            4'd3:    return {GLYPH_R, GLYPH_S, GLYPH_P, GLYPH_BLANK};
            4'd4:    return {GLYPH_R, GLYPH_X_LEFT, GLYPH_X_RIGHT, GLYPH_A};
            4'd5:    return {GLYPH_R, GLYPH_X_LEFT, GLYPH_X_RIGHT, GLYPH_B};
            4'd6:    return {GLYPH_R, GLYPH_B, GLYPH_A, GLYPH_BLANK};
            4'd7:    return {GLYPH_R, GLYPH_B, GLYPH_B, GLYPH_BLANK};
            4'd8:    return {GLYPH_R, GLYPH_P, GLYPH_C, GLYPH_BLANK};
            4'd9:    return {GLYPH_R, GLYPH_F, GLYPH_R, GLYPH_BLANK};
            4'd10:   return {GLYPH_R, GLYPH_M_LEFT, GLYPH_M_RIGHT, GLYPH_A};
            4'd11:   return {GLYPH_R, GLYPH_I, GLYPH_O, GLYPH_BLANK};
            4'd12:   return {GLYPH_R, GLYPH_T_LEFT, GLYPH_T_RIGHT, GLYPH_1};
            4'd13:   return {GLYPH_R, GLYPH_T_LEFT, GLYPH_T_RIGHT, GLYPH_2};
            4'd14:   return {GLYPH_R, GLYPH_I, GLYPH_R, GLYPH_BLANK};
            default: return {GLYPH_R, GLYPH_BLANK, GLYPH_BLANK, GLYPH_BLANK};
        endcase
    endfunction

    // Phase mnemonics rSt FEt dCd Adr LdS Ldd nLd EhE Sto IPC
    function automatic logic [23:0] mnemonic_ref(input logic [3:0] phase);
        case (phase)
            4'd0:    return {GLYPH_R, GLYPH_S, GLYPH_T};
            4'd1:    return {GLYPH_F, GLYPH_E, GLYPH_T};
            4'd2:    return {GLYPH_D, GLYPH_C, GLYPH_D};
            4'd3:    return {GLYPH_A, GLYPH_D, GLYPH_R};
            4'd4:    return {GLYPH_L, GLYPH_D, GLYPH_S};
            4'd5:    return {GLYPH_L, GLYPH_D, GLYPH_D};
            4'd6:    return {GLYPH_N, GLYPH_L, GLYPH_D};
            4'd7:    return {GLYPH_E, GLYPH_H, GLYPH_E};
            4'd8:    return {GLYPH_S, GLYPH_T, GLYPH_O_LOW};
            4'd9:    return {GLYPH_I, GLYPH_P, GLYPH_C};
            default: return {GLYPH_BLANK, GLYPH_BLANK, GLYPH_BLANK};
        endcase
    endfunction

    function automatic logic [7:0] expected_glyph(
        input logic [1:0]  view,
        input logic [2:0]  idx,
        input logic [3:0]  addr,
        input logic [15:0] regs,
        input logic [15:0] ram,
        input logic [15:0] bus,
        input logic [15:0] state
    );
        logic [3:0][7:0] label;
        logic [2:0][7:0] mnem;
        logic [3:0][3:0] nib;
        label = label_ref(view, addr);
        mnem  = mnemonic_ref(state[7:4]);
        case (view)
            2'd0:    nib = regs;
            2'd1:    nib = ram;
            default: nib = bus;
        endcase
        if (idx[2]) return label[idx[1:0]];
        if (view != 2'd3) return HEX_REF[nib[idx[1:0]]];
        if (state[7:4] > 4'd9) return GLYPH_BLANK;    // Phases A..F
        if (idx != 3'd0) return mnem[idx[1:0] - 2'd1];
        return (state[1:0] == 2'd0) ? GLYPH_BLANK : HEX_REF[{2'b00, state[1:0]}];
    endfunction

    // Outputs are settled at the falling edge
    always @(negedge i_w_clk) begin
        if (!i_w_reset) begin
            model_view  <= 2'd0;
            model_digit <= 3'd0;
        end else begin
            exp_an              = 8'hff;
            exp_an[model_digit] = 1'b0;
            exp_seg = expected_glyph(model_view, model_digit, i_w_regs_addr,
                                     i_w_regs, i_w_ram, i_w_bus, i_w_state);
            checks  = checks + 1;
            if (i_w_an !== exp_an) begin
                errors = errors + 1;
                $display("mismatch at %0t ns: o_w_an expected %b, got %b",
                         $time, exp_an, i_w_an);
            end
            if (i_w_7_led_seg !== exp_seg) begin
                errors = errors + 1;
                $display("mismatch at %0t ns: o_w_7_led_seg expected %b, got %b (digit %0d)",
                         $time, exp_seg, i_w_7_led_seg, model_digit);
            end
            model_digit <= model_digit + 3'd1;
            if (i_w_next) begin
                model_view <= model_view + 2'd1;    // Next wins over prev
            end else if (i_w_prev) begin
                model_view <= model_view - 2'd1;
            end
        end
    end

    assign o_errors = errors;
    assign o_checks = checks;

endmodule

// ==== dv/state_display_tb.sv ====
`timescale 1ns/10ps

module state_display_tb;

    import display_pkg::*;

    localparam int          CLK_PERIOD   = 20;
    localparam int          RESET_CYCLES = 8;
    localparam int          SCAN_HOLD    = 8;    // One full pass over the digits
    localparam int unsigned RAND_SEED    = 32'hc3ba995f;
    localparam int          TEST_CYCLES  = RESET_CYCLES + 8 + 16 + 16 * SCAN_HOLD + 64
                                           + 2 * (8 + 4 * SCAN_HOLD) + 8 + 64 * SCAN_HOLD;

    logic        clk;
    logic        rst_n;
    logic        next_btn;
    logic        prev_btn;
    reg_addr_t   regs_addr;
    word_t       regs_word;
    word_t       ram_word;
    word_t       bus_word;
    word_t       state_word;
    logic [7:0]  an;
    seg_t        seg;
    int          errors;
    int          checks;
    int          test_num = 1;
    int          failed_tests = 0;
    int          errors_before = 0;
    logic [1:0]  cur_view = 2'd0;    // View as the stimulus expects it

    state_display dut_i (
        .i_w_clk       (clk),
        .i_w_reset     (rst_n),
        .i_w_next      (next_btn),
        .i_w_prev      (prev_btn),
        .i_w_regs_addr (regs_addr),
        .i_w_regs      (regs_word),
        .i_w_ram       (ram_word),
        .i_w_bus       (bus_word),
        .i_w_state     (state_word),
        .o_w_an        (an),
        .o_w_7_led_seg (seg)
    );

    display_checker checker_i (
        .i_w_clk       (clk),
        .i_w_reset     (rst_n),
        .i_w_next      (next_btn),
        .i_w_prev      (prev_btn),
        .i_w_regs_addr (regs_addr),
        .i_w_regs      (regs_word),
        .i_w_ram       (ram_word),
        .i_w_bus       (bus_word),
        .i_w_state     (state_word),
        .i_w_an        (an),
        .i_w_7_led_seg (seg),
        .o_errors      (errors),
        .o_checks      (checks)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(CLK_PERIOD * (TEST_CYCLES + 100));
        $display("watchdog expired before the tests finished");
        $display("Regression failed");
        $finish;
    end

    task automatic run_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic report_test(input string name);
        if (errors != errors_before) begin
            failed_tests = failed_tests + 1;
            $display("test %0d %s: FAILED with %0d errors", test_num, name, errors - errors_before);
        end else begin
            $display("test %0d %s: ok", test_num, name);
        end
        errors_before = errors;
        test_num      = test_num + 1;
    endtask

    // Hold next and/or prev for a number of cycles
    task automatic press(input logic nxt, input logic prv, input int cycles);
        @(posedge clk);
        next_btn <= nxt;
        prev_btn <= prv;
        repeat (cycles) @(posedge clk);
        next_btn <= 1'b0;
        prev_btn <= 1'b0;
        if (nxt) begin
            cur_view = cur_view + 2'(cycles);
        end else if (prv) begin
            cur_view = cur_view - 2'(cycles);
        end
    endtask

    task automatic goto_view(input logic [1:0] target);
        while (cur_view != target) begin
            press(1'b1, 1'b0, 1);
        end
    endtask

    task automatic apply_words(input logic [3:0] addr, input word_t regs, input word_t ram,
                               input word_t bus, input word_t state);
        regs_addr  <= addr;
        regs_word  <= regs;
        ram_word   <= ram;
        bus_word   <= bus;
        state_word <= state;
        run_cycles(SCAN_HOLD);
    endtask

    initial begin
        void'($urandom(RAND_SEED));
        rst_n      = 1'b0;
        next_btn   = 1'b0;
        prev_btn   = 1'b0;
        regs_addr  = '0;
        regs_word  = 16'h1234;
        ram_word   = 16'h5678;
        bus_word   = 16'h9abc;
        state_word = 16'h0010;
        run_cycles(RESET_CYCLES);
        rst_n <= 1'b1;

        run_cycles(8);
        report_test("reset state");
        run_cycles(16);
        report_test("scan order");

        for (int a = 0; a < 16; a++) begin
            apply_words(4'(a), 16'($urandom), 16'($urandom), 16'($urandom), 16'($urandom));
        end
        report_test("register view");

        repeat (5) press(1'b1, 1'b0, 1);
        repeat (6) press(1'b0, 1'b1, 1);
        press(1'b1, 1'b0, 6);
        press(1'b0, 1'b1, 3);
        press(1'b1, 1'b1, 3);
        run_cycles(3);
        report_test("view stepping");

        for (int v = 1; v < 3; v++) begin
            goto_view(2'(v));
            repeat (4) begin
                apply_words(4'($urandom), 16'($urandom), 16'($urandom), 16'($urandom),
                            16'($urandom));
            end
        end
        report_test("ram and bus views");

        goto_view(2'd3);
        for (int ph = 0; ph < 16; ph++) begin
            for (int st = 0; st < 4; st++) begin
                apply_words(4'($urandom), 16'($urandom), 16'($urandom), 16'($urandom),
                            {8'($urandom), 4'(ph), 2'($urandom), 2'(st)});
            end
        end
        report_test("fsm view");

        run_cycles(2);
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 test_num - 1, failed_tests, checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== hw/digit_scan.sv ====
`timescale 1ns/10ps

module digit_scan (
    input  logic                                  i_w_clk,
    input  logic                                  i_w_reset,
    input  display_pkg::display_frame_t           i_frame,
    output logic [display_pkg::NUM_DIGITS-1:0]    o_w_an,
    output display_pkg::seg_t                     o_w_7_led_seg
);

    import display_pkg::*;

    digit_idx_t                       l_r_digit;    // Digit being lit
    logic [NUM_DIGITS-1:0][SEG_W-1:0] l_w_digits;

    always_ff @(posedge i_w_clk or negedge i_w_reset) begin
        if (!i_w_reset) begin
            l_r_digit <= '0;
        end else begin
            l_r_digit <= l_r_digit + 1'b1;    // Free running and wraps at 8
        end
    end

    assign l_w_digits    = i_frame;
    assign o_w_an        = ~(NUM_DIGITS'(1) << l_r_digit);
    assign o_w_7_led_seg = l_w_digits[l_r_digit];

    a_one_anode : assert property (
        @(posedge i_w_clk) disable iff (!i_w_reset)
            $onehot(~o_w_an)
    ) else $error("anode bus is not one-hot low: %b", o_w_an);

endmodule

// ==== hw/display_pkg.sv ====
package display_pkg;

    localparam int DATA_W     = 16;
    localparam int NIBBLES    = 4;
    localparam int NUM_DIGITS = 8;
    localparam int SEG_W      = 8;

    typedef logic [DATA_W-1:0]             word_t;
    typedef logic [SEG_W-1:0]              seg_t;
    typedef logic [$clog2(NUM_DIGITS)-1:0] digit_idx_t;
    typedef logic [3:0]                    reg_addr_t;

    typedef enum logic [1:0] {
        VIEW_REGS = 2'd0,
        VIEW_RAM  = 2'd1,
        VIEW_BUS  = 2'd2,
        VIEW_FSM  = 2'd3
    } view_t;

    // Address 15 is left unnamed
    typedef enum logic [3:0] {
        REG_RA, REG_RB, REG_RC, REG_SP,
        REG_XA, REG_XB, REG_BA, REG_BB,
        REG_PC, REG_FR, REG_MA, REG_IOA,
        REG_T1, REG_T2, REG_IR
    } reg_id_t;

    // Major nibble of the control unit state code
    typedef enum logic [3:0] {
        PH_RESET    = 4'd0,
        PH_FETCH    = 4'd1,
        PH_DECODE   = 4'd2,
        PH_ADDR     = 4'd3,
        PH_LOAD_SRC = 4'd4,
        PH_LOAD_DST = 4'd5,
        PH_NOLOAD   = 4'd6,
        PH_EXEC     = 4'd7,
        PH_STORE    = 4'd8,
        PH_INC_PC   = 4'd9
    } cpu_phase_t;

`include "seg_glyphs.svh"

    typedef struct packed {
        seg_t dig3;    // Leftmost digit of the half
        seg_t dig2;
        seg_t dig1;
        seg_t dig0;
    } half_frame_t;

    typedef struct packed {
        half_frame_t upper;    // Digits 7..4
        half_frame_t lower;    // Digits 3..0
    } display_frame_t;

    function automatic seg_t hex_glyph(input logic [3:0] nibble);
        case (nibble)
            4'h0: return GLYPH_0;
            4'h1: return GLYPH_1;
            4'h2: return GLYPH_2;
            4'h3: return GLYPH_3;
            4'h4: return GLYPH_4;
            4'h5: return GLYPH_5;
            4'h6: return GLYPH_6;
            4'h7: return GLYPH_7;
            4'h8: return GLYPH_8;
            4'h9: return GLYPH_9;
            4'ha: return GLYPH_A;
            4'hb: return GLYPH_B;
            4'hc: return GLYPH_C;
            4'hd: return GLYPH_D;
            4'he: return GLYPH_E;
            default: return GLYPH_F;
        endcase
    endfunction

endpackage

// ==== hw/label_compose.sv ====
`timescale 1ns/10ps

module label_compose (
    input  display_pkg::view_t        i_view,
    input  display_pkg::reg_addr_t    i_regs_addr,
    output display_pkg::half_frame_t  o_label
);

    import display_pkg::*;

    logic [NIBBLES-1:0][SEG_W-1:0] l_w_label;    // [3] is digit 7

    always_comb begin
        l_w_label = {NIBBLES{GLYPH_BLANK}};
        case (i_view)
            VIEW_REGS: begin
                l_w_label[3] = GLYPH_R;
                case (reg_id_t'(i_regs_addr))
                    REG_RA:  l_w_label[2:0] = {GLYPH_R, GLYPH_A, GLYPH_BLANK};
                    REG_RB:  l_w_label[2:0] = {GLYPH_R, GLYPH_B, GLYPH_BLANK};
                    REG_RC:  l_w_label[2:0] = {GLYPH_R, GLYPH_C, GLYPH_BLANK};
                    REG_SP:  l_w_label[2:0] = {GLYPH_S, GLYPH_P, GLYPH_BLANK};
                    REG_XA:  l_w_label[2:0] = {GLYPH_X_LEFT, GLYPH_X_RIGHT, GLYPH_A};
                    REG_XB:  l_w_label[2:0] = {GLYPH_X_LEFT, GLYPH_X_RIGHT, GLYPH_B};
                    REG_BA:  l_w_label[2:0] = {GLYPH_B, GLYPH_A, GLYPH_BLANK};
                    REG_BB:  l_w_label[2:0] = {GLYPH_B, GLYPH_B, GLYPH_BLANK};
                    REG_PC:  l_w_label[2:0] = {GLYPH_P, GLYPH_C, GLYPH_BLANK};
                    REG_FR:  l_w_label[2:0] = {GLYPH_F, GLYPH_R, GLYPH_BLANK};
                    REG_MA:  l_w_label[2:0] = {GLYPH_M_LEFT, GLYPH_M_RIGHT, GLYPH_A};
                    REG_IOA: l_w_label[2:0] = {GLYPH_I, GLYPH_O, GLYPH_BLANK};
                    REG_T1:  l_w_label[2:0] = {GLYPH_T_LEFT, GLYPH_T_RIGHT, GLYPH_1};
                    REG_T2:  l_w_label[2:0] = {GLYPH_T_LEFT, GLYPH_T_RIGHT, GLYPH_2};
                    REG_IR:  l_w_label[2:0] = {GLYPH_I, GLYPH_R, GLYPH_BLANK};
                    default: l_w_label[2:0] = {3{GLYPH_BLANK}};    // Address 15 shows only r
                endcase
            end
            VIEW_RAM: begin
                l_w_label = {GLYPH_M_LEFT, GLYPH_M_RIGHT, GLYPH_A, GLYPH_R};
            end
            VIEW_BUS: begin
                l_w_label = {GLYPH_B, GLYPH_U, GLYPH_S, GLYPH_BLANK};
            end
            default: begin
                l_w_label = {GLYPH_F, GLYPH_S, GLYPH_M_LEFT, GLYPH_M_RIGHT};
            end
        endcase
    end

    assign o_label = l_w_label;

endmodule

// ==== hw/state_display.sv ====
`timescale 1ns/10ps

module state_display (
    input  logic                                 i_w_clk,
    input  logic                                 i_w_reset,
    input  logic                                 i_w_next,
    input  logic                                 i_w_prev,
    input  display_pkg::reg_addr_t               i_w_regs_addr,
    input  display_pkg::word_t                   i_w_regs,
    input  display_pkg::word_t                   i_w_ram,
    input  display_pkg::word_t                   i_w_bus,
    input  display_pkg::word_t                   i_w_state,
    output logic [display_pkg::NUM_DIGITS-1:0]   o_w_an,
    output display_pkg::seg_t                    o_w_7_led_seg
);

    import display_pkg::*;

    view_t          l_w_view;
    half_frame_t    l_w_label;
    half_frame_t    l_w_value;
    display_frame_t l_w_frame;

    view_select u_view_select (
        .i_w_clk   (i_w_clk),
        .i_w_reset (i_w_reset),
        .i_w_next  (i_w_next),
        .i_w_prev  (i_w_prev),
        .o_view    (l_w_view)
    );

    label_compose u_label_compose (
        .i_view      (l_w_view),
        .i_regs_addr (i_w_regs_addr),
        .o_label     (l_w_label)
    );

    value_compose u_value_compose (
        .i_view  (l_w_view),
        .i_regs  (i_w_regs),
        .i_ram   (i_w_ram),
        .i_bus   (i_w_bus),
        .i_state (i_w_state),
        .o_value (l_w_value)
    );

    assign l_w_frame = '{upper: l_w_label, lower: l_w_value};

    digit_scan u_digit_scan (
        .i_w_clk       (i_w_clk),
        .i_w_reset     (i_w_reset),
        .i_frame       (l_w_frame),
        .o_w_an        (o_w_an),
        .o_w_7_led_seg (o_w_7_led_seg)
    );

endmodule

// ==== hw/value_compose.sv ====
`timescale 1ns/10ps

module value_compose (
    input  display_pkg::view_t        i_view,
    input  display_pkg::word_t        i_regs,
    input  display_pkg::word_t        i_ram,
    input  display_pkg::word_t        i_bus,
    input  display_pkg::word_t        i_state,
    output display_pkg::half_frame_t  o_value
);

    import display_pkg::*;

    word_t                         l_w_word;
    logic [NIBBLES-1:0][SEG_W-1:0] l_w_hex;
    cpu_phase_t                    l_w_phase;
    logic [1:0]                    l_w_step;
    logic [2:0][SEG_W-1:0]         l_w_mnemonic;    // [2] is digit 3
    logic                          l_w_phase_valid;

    assign l_w_phase = cpu_phase_t'(i_state[7:4]);
    assign l_w_step  = i_state[1:0];    // Bits 3..2 are don't care

    always_comb begin
        case (i_view)
            VIEW_REGS: l_w_word = i_regs;
            VIEW_RAM:  l_w_word = i_ram;
            VIEW_BUS:  l_w_word = i_bus;
            default:   l_w_word = '0;
        endcase
        for (int i = 0; i < NIBBLES; i++) begin
            l_w_hex[i] = hex_glyph(l_w_word[i*4 +: 4]);
        end
    end

    always_comb begin
        l_w_mnemonic    = {3{GLYPH_BLANK}};
        l_w_phase_valid = 1'b1;
        case (l_w_phase)
            PH_RESET:    l_w_mnemonic = {GLYPH_R, GLYPH_S, GLYPH_T};
            PH_FETCH:    l_w_mnemonic = {GLYPH_F, GLYPH_E, GLYPH_T};
            PH_DECODE:   l_w_mnemonic = {GLYPH_D, GLYPH_C, GLYPH_D};
            PH_ADDR:     l_w_mnemonic = {GLYPH_A, GLYPH_D, GLYPH_R};
            PH_LOAD_SRC: l_w_mnemonic = {GLYPH_L, GLYPH_D, GLYPH_S};
            PH_LOAD_DST: l_w_mnemonic = {GLYPH_L, GLYPH_D, GLYPH_D};
            PH_NOLOAD:   l_w_mnemonic = {GLYPH_N, GLYPH_L, GLYPH_D};
            PH_EXEC:     l_w_mnemonic = {GLYPH_E, GLYPH_H, GLYPH_E};
            PH_STORE:    l_w_mnemonic = {GLYPH_S, GLYPH_T, GLYPH_O_LOW};
            PH_INC_PC:   l_w_mnemonic = {GLYPH_I, GLYPH_P, GLYPH_C};
            default:     l_w_phase_valid = 1'b0;    // Nibbles A..F stay blank
        endcase
    end

    always_comb begin
        if (i_view == VIEW_FSM) begin
            o_value.dig3 = l_w_mnemonic[2];
            o_value.dig2 = l_w_mnemonic[1];
            o_value.dig1 = l_w_mnemonic[0];
            if (l_w_phase_valid && l_w_step != 2'd0) begin
                o_value.dig0 = hex_glyph({2'b00, l_w_step});
            end else begin
                o_value.dig0 = GLYPH_BLANK;
            end
        end else begin
            o_value = l_w_hex;
        end
        if (!$isunknown({i_view, i_regs, i_ram, i_bus, i_state})) begin
            a_value_known : assert (!$isunknown(o_value))
                else $error("lower digits unknown with known inputs");
        end
    end

endmodule

// ==== hw/view_select.sv ====
`timescale 1ns/10ps

module view_select (
    input  logic                i_w_clk,
    input  logic                i_w_reset,
    input  logic                i_w_next,
    input  logic                i_w_prev,
    output display_pkg::view_t  o_view
);

    import display_pkg::*;

    // Two-bit view wraps by itself; next has priority
    always_ff @(posedge i_w_clk or negedge i_w_reset) begin
        if (!i_w_reset) begin
            o_view <= VIEW_REGS;
        end else if (i_w_next) begin
            o_view <= view_t'(o_view + 2'd1);
        end else if (i_w_prev) begin
            o_view <= view_t'(o_view - 2'd1);
        end
    end

    a_view_known : assert property (
        @(posedge i_w_clk) disable iff (!i_w_reset)
            !$isunknown(o_view)
    ) else $error("view register holds unknown bits");

endmodule

// ==== include/seg_glyphs.svh ====
`ifndef SEG_GLYPHS_SVH
`define SEG_GLYPHS_SVH

// Active-low glyphs with the dot in bit 7 and segment a in bit 0
localparam logic [7:0] GLYPH_BLANK   = 8'b1111_1111;

localparam logic [7:0] GLYPH_0       = 8'b1100_0000;
localparam logic [7:0] GLYPH_1       = 8'b1111_1001;
localparam logic [7:0] GLYPH_2       = 8'b1010_0100;
localparam logic [7:0] GLYPH_3       = 8'b1011_0000;
localparam logic [7:0] GLYPH_4       = 8'b1001_1001;
localparam logic [7:0] GLYPH_5       = 8'b1001_0010;
localparam logic [7:0] GLYPH_6       = 8'b1000_0010;
localparam logic [7:0] GLYPH_7       = 8'b1111_1000;
localparam logic [7:0] GLYPH_8       = 8'b1000_0000;
localparam logic [7:0] GLYPH_9       = 8'b1001_0000;

localparam logic [7:0] GLYPH_A       = 8'b1000_1000;
localparam logic [7:0] GLYPH_B       = 8'b1000_0011;    // Lower case b
localparam logic [7:0] GLYPH_C       = 8'b1100_0110;
localparam logic [7:0] GLYPH_D       = 8'b1010_0001;    // Lower case d
localparam logic [7:0] GLYPH_E       = 8'b1000_0110;
localparam logic [7:0] GLYPH_F       = 8'b1000_1110;
localparam logic [7:0] GLYPH_H       = 8'b1000_1011;    // Lower case h
localparam logic [7:0] GLYPH_I       = 8'b1111_1001;
localparam logic [7:0] GLYPH_L       = 8'b1100_0111;
localparam logic [7:0] GLYPH_N       = 8'b1010_1011;    // Lower case n
localparam logic [7:0] GLYPH_O       = 8'b1100_0000;
localparam logic [7:0] GLYPH_O_LOW   = 8'b1010_0011;
localparam logic [7:0] GLYPH_P       = 8'b1000_1100;
localparam logic [7:0] GLYPH_R       = 8'b1010_1111;    // Lower case r
localparam logic [7:0] GLYPH_S       = 8'b1001_0010;
localparam logic [7:0] GLYPH_T       = 8'b1000_0111;    // Lower case t
localparam logic [7:0] GLYPH_U       = 8'b1100_0001;

// Wide letters drawn across two digits
localparam logic [7:0] GLYPH_M_LEFT  = 8'b1100_1100;
localparam logic [7:0] GLYPH_M_RIGHT = 8'b1101_1000;
localparam logic [7:0] GLYPH_X_LEFT  = 8'b1111_0000;
localparam logic [7:0] GLYPH_X_RIGHT = 8'b1100_0110;
localparam logic [7:0] GLYPH_T_LEFT  = 8'b1111_1000;
localparam logic [7:0] GLYPH_T_RIGHT = 8'b1100_1110;

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the state display testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module state_display_tb \
    -f state_display.f \
    -o sim_state_display
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_state_display 2>&1)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Regression passed"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1

// ==== state_display.f ====
+incdir+include
hw/display_pkg.sv
hw/view_select.sv
hw/label_compose.sv
hw/value_compose.sv
hw/digit_scan.sv
hw/state_display.sv
dv/display_checker.sv
dv/state_display_tb.sv
